// File: verilog/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// Base ISA width, 64 for RV64I or 32 for RV32I
`define DECODE_XLEN 64

`define DECODE_OPCODE_W 7

// Exception cause codes
`define DECODE_CAUSE_ILLEGAL    4'd2
`define DECODE_CAUSE_BREAKPOINT 4'd3
// ECALL cause is this base plus the current privilege
`define DECODE_CAUSE_ECALL_BASE 4'd8

// Privilege level encodings
`define DECODE_PRV_U 2'd0
`define DECODE_PRV_S 2'd1
`define DECODE_PRV_M 2'd3

`endif

// File: verilog/decode_pkg.sv
`default_nettype none

package decode_pkg;

    `include "decode_cfg.svh"

    typedef logic [`DECODE_XLEN-1:0] xlen_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [3:0] cause_t;

    // Major opcodes handled by the decoder
    typedef enum logic [`DECODE_OPCODE_W-1:0] {
        OPCODE_LOAD      = 7'b0000011,
        OPCODE_MISC_MEM  = 7'b0001111,
        OPCODE_OP_IMM    = 7'b0010011,
        OPCODE_AUIPC     = 7'b0010111,
        OPCODE_OP_IMM_32 = 7'b0011011,
        OPCODE_STORE     = 7'b0100011,
        OPCODE_OP        = 7'b0110011,
        OPCODE_LUI       = 7'b0110111,
        OPCODE_OP_32     = 7'b0111011,
        OPCODE_BRANCH    = 7'b1100011,
        OPCODE_JALR      = 7'b1100111,
        OPCODE_JAL       = 7'b1101111,
        OPCODE_SYSTEM    = 7'b1110011
    } opcode_t;

    // Same 32-bit word, seen as R-type or as I-type fields
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            opcode_t    opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            reg_idx_t    rs1;
            logic [2:0]  funct3;
            reg_idx_t    rd;
            opcode_t     opcode;
        } i;
    } instr_t;

    typedef enum logic [2:0] {
        ALU, MEM, BRANCH, JALR, AUIPC, ERET, WFI
    } op_type_t;

    typedef enum logic [2:0] {
        ADDSUB, SLT, SLTU, L_XOR, L_OR, L_AND, SHIFT
    } alu_op_t;

    typedef enum logic [2:0] {
        EQ, NE, LT, GE, LTU, GEU, JUMP
    } cmp_op_t;

    typedef enum logic {
        MEM_LOAD, MEM_STORE
    } mem_op_t;

    typedef enum logic [1:0] {
        PRV_U = `DECODE_PRV_U,
        PRV_S = `DECODE_PRV_S,
        PRV_M = `DECODE_PRV_M
    } prv_t;

endpackage

`default_nettype wire

// File: verilog/op_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module op_decoder
    import decode_pkg::*;
(
    input  instr_t     instr,
    input  prv_t       prv,
    input  logic       tsr,
    input  logic       tw,
    output op_type_t   op_type,
    output alu_op_t    alu_op,
    output logic       subtract,
    output logic       shift_left,
    output logic       shift_arith,
    output logic       is_32,
    output cmp_op_t    cmp_op,
    output mem_op_t    mem_op,
    output logic [1:0] mem_size,
    output logic       mem_zeroext,
    output reg_idx_t   rs1,
    output reg_idx_t   rs2,
    output reg_idx_t   rd,
    output logic       dec_illegal,
    output logic       is_ecall,
    output logic       is_ebreak
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr.r.opcode;
    assign funct3 = instr.r.funct3;
    assign funct7 = instr.r.funct7;

    // ALU function shared by register and immediate forms
    function automatic alu_op_t alu_sel(input logic [2:0] f3);
        case (f3)
            3'b010:         return SLT;
            3'b011:         return SLTU;
            3'b100:         return L_XOR;
            3'b110:         return L_OR;
            3'b111:         return L_AND;
            3'b001, 3'b101: return SHIFT;
            default:        return ADDSUB;
        endcase
    endfunction

    always_comb begin
        op_type     = ALU;
        alu_op      = ADDSUB;
        subtract    = 1'b0;
        shift_left  = 1'b0;
        shift_arith = 1'b0;
        is_32       = 1'b0;
        cmp_op      = EQ;
        mem_op      = MEM_LOAD;
        mem_size    = funct3[1:0];
        mem_zeroext = 1'b0;
        rs1         = '0;
        rs2         = '0;
        rd          = '0;
        dec_illegal = 1'b0;
        is_ecall    = 1'b0;
        is_ebreak   = 1'b0;

        case (opcode)
            OPCODE_LOAD: begin
                op_type     = MEM;
                rs1         = instr.r.rs1;
                rd          = instr.r.rd;
                mem_zeroext = funct3[2];
                dec_illegal = (`DECODE_XLEN == 32) ?
                              (funct3[1:0] == 2'b11 || funct3 == 3'b110) : (funct3 == 3'b111);
            end
            OPCODE_STORE: begin
                op_type     = MEM;
                mem_op      = MEM_STORE;
                rs1         = instr.r.rs1;
                rs2         = instr.r.rs2;
                dec_illegal = funct3[2] || (`DECODE_XLEN == 32 && funct3[1:0] == 2'b11);
            end
            OPCODE_OP, OPCODE_OP_32, OPCODE_OP_IMM, OPCODE_OP_IMM_32: begin
                rs1         = instr.r.rs1;
                rd          = instr.r.rd;
                is_32       = opcode inside {OPCODE_OP_32, OPCODE_OP_IMM_32};
                alu_op      = alu_sel(funct3);
                shift_left  = funct3 == 3'b001;
                shift_arith = funct3 == 3'b101 && funct7[5];
                if (opcode inside {OPCODE_OP, OPCODE_OP_32}) begin
                    rs2         = instr.r.rs2;
                    subtract    = funct3 == 3'b000 && funct7[5];
                    dec_illegal = !(funct7 == 7'b0 ||
                                    (funct7 == 7'b0100000 && funct3 inside {3'b000, 3'b101}));
                end else if (alu_op == SHIFT) begin
                    // funct7[0] is the top shamt bit, valid only for full 64-bit shifts
                    dec_illegal = {funct7[6], funct7[4:1]} != 5'b0 || (funct7[5] && shift_left) ||
                                  (funct7[0] && (is_32 || `DECODE_XLEN == 32));
                end
                // Word forms exist only on RV64, and only as add, sub and shifts
                if (is_32 && (`DECODE_XLEN == 32 || !(funct3 inside {3'b000, 3'b001, 3'b101})))
                begin
                    dec_illegal = 1'b1;
                end
            end
            OPCODE_LUI: begin
                rd = instr.r.rd;
            end
            OPCODE_AUIPC: begin
                op_type = AUIPC;
                rd      = instr.r.rd;
            end
            OPCODE_BRANCH: begin
                op_type  = BRANCH;
                rs1      = instr.r.rs1;
                rs2      = instr.r.rs2;
                subtract = 1'b1;
                case (funct3)
                    3'b000:  cmp_op = EQ;
                    3'b001:  cmp_op = NE;
                    3'b100:  cmp_op = LT;
                    3'b101:  cmp_op = GE;
                    3'b110:  cmp_op = LTU;
                    3'b111:  cmp_op = GEU;
                    default: dec_illegal = 1'b1;
                endcase
            end
            OPCODE_JAL: begin
                op_type = BRANCH;
                cmp_op  = JUMP;
                rd      = instr.r.rd;
            end
            OPCODE_JALR: begin
                op_type     = JALR;
                rs1         = instr.r.rs1;
                rd          = instr.r.rd;
                dec_illegal = funct3 != 3'b000;
            end
            OPCODE_MISC_MEM: begin
                // FENCE goes through as a no-op
                dec_illegal = funct3 != 3'b000;
            end
            OPCODE_SYSTEM: begin
                if (funct3 != 3'b000) begin
                    dec_illegal = 1'b1;
                end else begin
                    case ({funct7, instr.r.rs2})
                        12'b0000000_00000: is_ecall = 1'b1;
                        12'b0000000_00001: is_ebreak = 1'b1;
                        12'b0011000_00010: begin
                            op_type     = ERET;
                            dec_illegal = prv != PRV_M;
                        end
                        12'b0001000_00010: begin
                            op_type     = ERET;
                            dec_illegal = prv != PRV_M && (prv != PRV_S || tsr);
                        end
                        12'b0001000_00101: begin
                            op_type     = WFI;
                            dec_illegal = prv != PRV_M && (prv != PRV_S || tw);
                        end
                        default: dec_illegal = 1'b1;
                    endcase
                end
            end
            default: dec_illegal = 1'b1;
        endcase

        if (alu_op == SLT || alu_op == SLTU) subtract = 1'b1; // compare via adder
    end

endmodule

`default_nettype wire

// File: verilog/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen
    import decode_pkg::*;
(
    input  instr_t instr,
    output xlen_t  imm,
    output logic   use_imm
);

    logic signed [11:0] i_imm;
    logic signed [11:0] s_imm;
    logic signed [12:0] b_imm;
    logic signed [31:0] u_imm;
    logic signed [20:0] j_imm;

    assign i_imm = instr.i.imm;
    assign s_imm = {instr.r.funct7, instr.r.rd};
    assign b_imm = {instr.r.funct7[6], instr.r.rd[0], instr.r.funct7[5:0], instr.r.rd[4:1], 1'b0};
    assign u_imm = {instr.i.imm, instr.i.rs1, instr.i.funct3, 12'b0};
    // J-type bits scatter over the imm, rs1 and funct3 fields
    assign j_imm = {instr.i.imm[11], instr.i.rs1, instr.i.funct3, instr.i.imm[0],
                    instr.i.imm[10:1], 1'b0};

    always_comb begin
        imm     = '0;
        use_imm = 1'b0;
        case (instr.i.opcode)
            OPCODE_LOAD, OPCODE_OP_IMM, OPCODE_OP_IMM_32, OPCODE_JALR: begin
                imm     = xlen_t'(i_imm);
                use_imm = 1'b1;
            end
            OPCODE_LUI, OPCODE_AUIPC: begin
                imm     = xlen_t'(u_imm);
                use_imm = 1'b1;
            end
            OPCODE_STORE: begin
                imm     = xlen_t'(s_imm);
                use_imm = 1'b1;
            end
            // Branch and jump offsets feed the PC adder only
            OPCODE_BRANCH: imm = xlen_t'(b_imm);
            OPCODE_JAL:    imm = xlen_t'(j_imm);
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/decode_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module decode_issue
    import decode_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       instr_valid,
    input  logic [31:0] instr_word,
    input  xlen_t      instr_pc,
    input  logic       fetch_fault,
    input  cause_t     fetch_cause,
    input  xlen_t      fetch_tval,
    input  prv_t       prv,
    input  op_type_t   op_type,
    input  alu_op_t    alu_op,
    input  logic       subtract,
    input  logic       shift_left,
    input  logic       shift_arith,
    input  logic       is_32,
    input  cmp_op_t    cmp_op,
    input  mem_op_t    mem_op,
    input  logic [1:0] mem_size,
    input  logic       mem_zeroext,
    input  reg_idx_t   rs1,
    input  reg_idx_t   rs2,
    input  reg_idx_t   rd,
    input  logic       dec_illegal,
    input  logic       is_ecall,
    input  logic       is_ebreak,
    input  xlen_t      imm,
    input  logic       use_imm,
    output logic       dec_valid,
    output xlen_t      dec_pc,
    output op_type_t   dec_op_type,
    output alu_op_t    dec_alu_op,
    output logic       dec_subtract,
    output logic       dec_shift_left,
    output logic       dec_shift_arith,
    output logic       dec_is_32,
    output cmp_op_t    dec_cmp_op,
    output mem_op_t    dec_mem_op,
    output logic [1:0] dec_mem_size,
    output logic       dec_mem_zeroext,
    output reg_idx_t   dec_rs1,
    output reg_idx_t   dec_rs2,
    output reg_idx_t   dec_rd,
    output xlen_t      dec_imm,
    output logic       dec_use_imm,
    output logic       dec_exc_valid,
    output cause_t     dec_exc_cause,
    output xlen_t      dec_exc_tval
);

    logic   exc_valid;
    cause_t exc_cause;
    xlen_t  exc_tval;

    // Fetch fault first, then ecall, ebreak and illegal
    always_comb begin
        exc_valid = fetch_fault | is_ecall | is_ebreak | dec_illegal;
        exc_cause = `DECODE_CAUSE_ILLEGAL;
        exc_tval  = '0;
        if (fetch_fault) begin
            exc_cause = fetch_cause;
            exc_tval  = fetch_tval;
        end else if (is_ecall) begin
            exc_cause = `DECODE_CAUSE_ECALL_BASE + {2'b00, prv};
        end else if (is_ebreak) begin
            exc_cause = `DECODE_CAUSE_BREAKPOINT;
        end else if (dec_illegal) begin
            exc_tval = xlen_t'(instr_word);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            dec_pc          <= instr_pc;
            dec_op_type     <= op_type;
            dec_alu_op      <= alu_op;
            dec_subtract    <= subtract;
            dec_shift_left  <= shift_left;
            dec_shift_arith <= shift_arith;
            dec_is_32       <= is_32;
            dec_cmp_op      <= cmp_op;
            dec_mem_op      <= mem_op;
            dec_mem_size    <= mem_size;
            dec_mem_zeroext <= mem_zeroext;
            dec_rs1         <= rs1;
            dec_rs2         <= rs2;
            dec_rd          <= rd;
            dec_imm         <= imm;
            dec_use_imm     <= use_imm;
            dec_exc_valid   <= exc_valid;
            dec_exc_cause   <= exc_cause;
            dec_exc_tval    <= exc_tval;
        end
    end

endmodule

`default_nettype wire

// File: verilog/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder
    import decode_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr_word,
    input  xlen_t       instr_pc,
    input  logic        fetch_fault,
    input  cause_t      fetch_cause,
    input  xlen_t       fetch_tval,
    input  prv_t        prv,
    input  logic        tsr,
    input  logic        tw,
    output logic        dec_valid,
    output xlen_t       dec_pc,
    output op_type_t    dec_op_type,
    output alu_op_t     dec_alu_op,
    output logic        dec_subtract,
    output logic        dec_shift_left,
    output logic        dec_shift_arith,
    output logic        dec_is_32,
    output cmp_op_t     dec_cmp_op,
    output mem_op_t     dec_mem_op,
    output logic [1:0]  dec_mem_size,
    output logic        dec_mem_zeroext,
    output reg_idx_t    dec_rs1,
    output reg_idx_t    dec_rs2,
    output reg_idx_t    dec_rd,
    output xlen_t       dec_imm,
    output logic        dec_use_imm,
    output logic        dec_exc_valid,
    output cause_t      dec_exc_cause,
    output xlen_t       dec_exc_tval
);

    instr_t     instr;
    op_type_t   op_type;
    alu_op_t    alu_op;
    logic       subtract;
    logic       shift_left;
    logic       shift_arith;
    logic       is_32;
    cmp_op_t    cmp_op;
    mem_op_t    mem_op;
    logic [1:0] mem_size;
    logic       mem_zeroext;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    logic       dec_illegal;
    logic       is_ecall;
    logic       is_ebreak;
    xlen_t      imm;
    logic       use_imm;

    assign instr = instr_t'(instr_word);

    // Control and immediate decode run side by side ahead of the output register
    op_decoder u_op_decoder (.*);

    imm_gen u_imm_gen (.*);

    decode_issue u_decode_issue (.*);

endmodule

`default_nettype wire

// File: tests/decoder_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decoder_tb
    import decode_pkg::*;
();

    // About 170 instructions at two cycles each, with ample margin
    localparam int MAX_CYCLES = 2000;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr_word;
    xlen_t       instr_pc;
    logic        fetch_fault;
    cause_t      fetch_cause;
    xlen_t       fetch_tval;
    prv_t        prv;
    logic        tsr;
    logic        tw;
    logic        dec_valid;
    xlen_t       dec_pc;
    op_type_t    dec_op_type;
    alu_op_t     dec_alu_op;
    logic        dec_subtract;
    logic        dec_shift_left;
    logic        dec_shift_arith;
    logic        dec_is_32;
    cmp_op_t     dec_cmp_op;
    mem_op_t     dec_mem_op;
    logic [1:0]  dec_mem_size;
    logic        dec_mem_zeroext;
    reg_idx_t    dec_rs1;
    reg_idx_t    dec_rs2;
    reg_idx_t    dec_rd;
    xlen_t       dec_imm;
    logic        dec_use_imm;
    logic        dec_exc_valid;
    cause_t      dec_exc_cause;
    xlen_t       dec_exc_tval;

    logic [31:0] seed;
    int          cycles = 0;

    rv_decoder dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_fail(input string line);
        $display("%s", line);
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            report_fail($sformatf("Run timed out after %0d cycles", MAX_CYCLES));
        end
    end

    function automatic logic [31:0] rand_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Instruction encoders, one per RISC-V format
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPCODE_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL};
    endfunction

    function automatic xlen_t sext(input logic [31:0] v, input int bits);
        logic signed [31:0] t;
        t = v << (32 - bits);
        t = t >>> (32 - bits);
        return xlen_t'(t);
    endfunction

    task automatic check_op_type(input string name, input op_type_t exp, input op_type_t act);
        if (act !== exp) begin
            report_fail($sformatf("Fail %s: expected %s, actual %s", name, exp.name(), act.name()));
        end
    endtask

    task automatic check_alu_op(input string name, input alu_op_t exp, input alu_op_t act);
        if (act !== exp) begin
            report_fail($sformatf("Fail %s: expected %s, actual %s", name, exp.name(), act.name()));
        end
    endtask

    task automatic check_cmp_op(input string name, input cmp_op_t exp, input cmp_op_t act);
        if (act !== exp) begin
            report_fail($sformatf("Fail %s: expected %s, actual %s", name, exp.name(), act.name()));
        end
    endtask

    task automatic check_mem_op(input string name, input mem_op_t exp, input mem_op_t act);
        if (act !== exp) begin
            report_fail($sformatf("Fail %s: expected %s, actual %s", name, exp.name(), act.name()));
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            report_fail($sformatf("Fail %s: expected x%0d, actual x%0d", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            report_fail($sformatf("Fail %s: expected 0x%h, actual 0x%h", name, exp, act));
        end
    endtask

    task automatic check_cause(input string name, input cause_t exp, input cause_t act);
        if (act !== exp) begin
            report_fail($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_fail($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic wait_valid(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!dec_valid && n < 4) begin
            @(negedge clk);
            n++;
        end
        if (!dec_valid) begin
            report_fail($sformatf("%s: dec_valid never rose after the instruction", name));
        end
    endtask

    // One instruction in, then wait for its decoded bundle
    task automatic run_one(input string name, input logic [31:0] w, input logic fault = 1'b0,
                           input cause_t fc = '0, input xlen_t ft = '0);
        xlen_t pc;
        pc = {rand_next(), rand_next()} & ~xlen_t'(3);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr_word  <= w;
        instr_pc    <= pc;
        fetch_fault <= fault;
        fetch_cause <= fc;
        fetch_tval  <= ft;
        @(posedge clk);
        instr_valid <= 1'b0;
        fetch_fault <= 1'b0;
        wait_valid(name);
        check_word({name, " pc"}, pc, dec_pc);
    endtask

    task automatic expect_illegal(input string name, input logic [31:0] w);
        check_bit({name, " exc"}, 1'b1, dec_exc_valid);
        check_cause({name, " cause"}, 4'd2, dec_exc_cause);
        check_word({name, " tval"}, xlen_t'(w), dec_exc_tval);
    endtask

    task automatic set_priv(input prv_t p, input logic s, input logic w);
        @(posedge clk);
        prv <= p;
        tsr <= s;
        tw  <= w;
    endtask

    task automatic test_reset_timing();
        logic [31:0] w[4];
        xlen_t       pc[4];
        reg_idx_t    rd[4];
        @(negedge clk);
        check_bit("reset dec_valid", 1'b0, dec_valid);
        for (int i = 0; i < 4; i++) begin
            rd[i] = reg_idx_t'(i * 7 + 3);
            w[i]  = enc_i(12'(i), 5'd1, 3'b000, rd[i], OPCODE_OP_IMM);
            pc[i] = xlen_t'(32'h1000 + 4 * i);
        end
        @(posedge clk);
        instr_valid <= 1'b1;
        instr_word  <= w[0];
        instr_pc    <= pc[0];
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            instr_valid <= i < 2;
            instr_word  <= w[i + 1];
            instr_pc    <= pc[i + 1];
            @(negedge clk);
            check_bit("back-to-back valid", 1'b1, dec_valid);
            check_reg("back-to-back rd", rd[i], dec_rd);
            check_word("back-to-back pc", pc[i], dec_pc);
        end
        @(negedge clk);
        check_bit("back-to-back idle", 1'b0, dec_valid);
    endtask

    task automatic test_alu();
        logic [31:0] r;
        logic [31:0] w;
        logic [11:0] imm;
        logic [2:0]  f3;
        alu_op_t     alu_by_f3[8];
        // ALU function for each funct3 value
        alu_by_f3 = '{ADDSUB, SHIFT, SLT, SLTU, L_XOR, SHIFT, L_OR, L_AND};
        for (int k = 0; k < 8; k++) begin
            f3 = 3'(k);
            r  = rand_next();
            w  = enc_r(7'h00, r[14:10], r[9:5], f3, r[4:0], OPCODE_OP);
            run_one("op", w);
            check_alu_op("op alu_op", alu_by_f3[k], dec_alu_op);
            check_bit("op subtract", f3 == 3'd2 || f3 == 3'd3, dec_subtract);
            check_bit("op shift_left", f3 == 3'd1, dec_shift_left);
            check_bit("op shift_arith", 1'b0, dec_shift_arith);
            check_bit("op is_32", 1'b0, dec_is_32);
            check_reg("op rs1", r[9:5], dec_rs1);
            check_reg("op rs2", r[14:10], dec_rs2);
            check_reg("op rd", r[4:0], dec_rd);
            check_bit("op exc", 1'b0, dec_exc_valid);
            // Shift immediates carry a 6-bit shamt with zero upper bits
            imm = (f3 == 3'd1 || f3 == 3'd5) ? {6'b0, r[20:15]} : r[26:15];
            w   = enc_i(imm, r[9:5], f3, r[4:0], OPCODE_OP_IMM);
            run_one("op_imm", w);
            check_alu_op("op_imm alu_op", alu_by_f3[k], dec_alu_op);
            check_reg("op_imm rs1", r[9:5], dec_rs1);
            check_reg("op_imm rs2", 5'd0, dec_rs2);
            check_word("op_imm imm", sext(32'(imm), 12), dec_imm);
            check_bit("op_imm use_imm", 1'b1, dec_use_imm);
            check_bit("op_imm exc", 1'b0, dec_exc_valid);
        end
        run_one("sub", enc_r(7'h20, 5'd3, 5'd2, 3'd0, 5'd1, OPCODE_OP));
        check_alu_op("sub alu_op", ADDSUB, dec_alu_op);
        check_bit("sub subtract", 1'b1, dec_subtract);
        run_one("sra", enc_r(7'h20, 5'd3, 5'd2, 3'd5, 5'd1, OPCODE_OP));
        check_bit("sra arith", 1'b1, dec_shift_arith);
        check_bit("sra left", 1'b0, dec_shift_left);
        run_one("srai", enc_i(12'h43f, 5'd2, 3'd5, 5'd1, OPCODE_OP_IMM));
        check_bit("srai arith", 1'b1, dec_shift_arith);
        check_bit("srai exc", 1'b0, dec_exc_valid);
        run_one("addw", enc_r(7'h00, 5'd3, 5'd2, 3'd0, 5'd1, OPCODE_OP_32));
        check_bit("addw is_32", 1'b1, dec_is_32);
        check_bit("addw exc", 1'b0, dec_exc_valid);
        run_one("slliw 31", enc_i(12'h01f, 5'd2, 3'd1, 5'd1, OPCODE_OP_IMM_32));
        check_bit("slliw is_32", 1'b1, dec_is_32);
        check_bit("slliw left", 1'b1, dec_shift_left);
        check_bit("slliw exc", 1'b0, dec_exc_valid);
        w = enc_i(12'h020, 5'd2, 3'd1, 5'd1, OPCODE_OP_IMM_32);
        run_one("slliw 32", w);
        expect_illegal("slliw 32", w);
        w = enc_i(12'h040, 5'd2, 3'd5, 5'd1, OPCODE_OP_IMM);
        run_one("srli 64", w);
        expect_illegal("srli 64", w);
    endtask

    task automatic imm_case(input string name, input logic [31:0] w, input xlen_t exp,
                            input logic use_exp);
        run_one(name, w);
        check_word({name, " imm"}, exp, dec_imm);
        check_bit({name, " use_imm"}, use_exp, dec_use_imm);
        check_bit({name, " exc"}, 1'b0, dec_exc_valid);
    endtask

    task automatic test_imm();
        logic [31:0] r;
        for (int k = 0; k < 8; k++) begin
            r = rand_next();
            imm_case("load", enc_i(r[11:0], 5'd4, 3'd3, 5'd5, OPCODE_LOAD),
                     sext(32'(r[11:0]), 12), 1'b1);
            imm_case("store", enc_s(r[11:0], 5'd6, 5'd4, 3'd2), sext(32'(r[11:0]), 12), 1'b1);
            imm_case("branch", enc_b({r[12:1], 1'b0}, 5'd6, 5'd4, 3'd0),
                     sext(32'({r[12:1], 1'b0}), 13), 1'b0);
            imm_case("jal", enc_j({r[20:1], 1'b0}, 5'd1), sext(32'({r[20:1], 1'b0}), 21),
                     1'b0);
            imm_case("lui", {r[31:12], 5'd7, OPCODE_LUI}, sext({r[31:12], 12'b0}, 32), 1'b1);
            imm_case("auipc", {r[31:12], 5'd7, OPCODE_AUIPC}, sext({r[31:12], 12'b0}, 32), 1'b1);
            check_op_type("auipc op_type", AUIPC, dec_op_type);
            imm_case("jalr", enc_i(r[11:0], 5'd4, 3'd0, 5'd1, OPCODE_JALR),
                     sext(32'(r[11:0]), 12), 1'b1);
            check_op_type("jalr op_type", JALR, dec_op_type);
        end
    endtask

    task automatic test_mem_branch();
        logic [31:0] r;
        logic [31:0] w;
        logic [2:0]  f3;
        logic [2:0]  bf3[6];
        cmp_op_t     bcmp[6];
        bf3  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        bcmp = '{EQ, NE, LT, GE, LTU, GEU};
        for (int k = 0; k < 8; k++) begin
            f3 = 3'(k);
            r  = rand_next();
            w  = enc_i(r[11:0], r[16:12], f3, r[21:17], OPCODE_LOAD);
            run_one("load", w);
            if (f3 == 3'd7) begin
                expect_illegal("load 111", w);
            end else begin
                check_op_type("load op_type", MEM, dec_op_type);
                check_mem_op("load mem_op", MEM_LOAD, dec_mem_op);
                check_word("load size", xlen_t'(f3[1:0]), xlen_t'(dec_mem_size));
                check_bit("load zeroext", f3[2], dec_mem_zeroext);
                check_reg("load rs1", r[16:12], dec_rs1);
                check_reg("load rd", r[21:17], dec_rd);
                check_bit("load exc", 1'b0, dec_exc_valid);
            end
            w = enc_s(r[11:0], r[26:22], r[16:12], f3);
            run_one("store", w);
            if (f3[2]) begin
                expect_illegal("store funct3", w);
            end else begin
                check_mem_op("store mem_op", MEM_STORE, dec_mem_op);
                check_word("store size", xlen_t'(f3[1:0]), xlen_t'(dec_mem_size));
                check_reg("store rs2", r[26:22], dec_rs2);
                check_bit("store exc", 1'b0, dec_exc_valid);
            end
        end
        for (int k = 0; k < 6; k++) begin
            run_one("branch", enc_b(13'h010, 5'd2, 5'd3, bf3[k]));
            check_op_type("branch op_type", BRANCH, dec_op_type);
            check_cmp_op("branch cmp_op", bcmp[k], dec_cmp_op);
            check_bit("branch exc", 1'b0, dec_exc_valid);
        end
        run_one("jal", enc_j(21'h000100, 5'd1));
        check_op_type("jal op_type", BRANCH, dec_op_type);
        check_cmp_op("jal cmp_op", JUMP, dec_cmp_op);
        check_reg("jal rd", 5'd1, dec_rd);
    endtask

    task automatic priv_case(input string name, input logic [31:0] w, input logic ok,
                             input op_type_t op);
        run_one(name, w);
        if (ok) begin
            check_bit({name, " exc"}, 1'b0, dec_exc_valid);
            check_op_type({name, " op_type"}, op, dec_op_type);
        end else begin
            expect_illegal(name, w);
        end
    endtask

    task automatic test_system();
        prv_t       levels[3];
        prv_t       p;
        logic [1:0] b;
        string      tag;
        levels = '{PRV_U, PRV_S, PRV_M};
        for (int l = 0; l < 3; l++) begin
            for (int k = 0; k < 4; k++) begin
                p   = levels[l];
                b   = 2'(k);
                tag = $sformatf(" prv%0d tsr%0d tw%0d", p, b[0], b[1]);
                set_priv(p, b[0], b[1]);
                run_one({"ecall", tag}, 32'h0000_0073);
                check_bit({"ecall exc", tag}, 1'b1, dec_exc_valid);
                check_cause({"ecall cause", tag}, 4'd8 + {2'b00, p}, dec_exc_cause);
                check_word({"ecall tval", tag}, '0, dec_exc_tval);
                run_one({"ebreak", tag}, 32'h0010_0073);
                check_bit({"ebreak exc", tag}, 1'b1, dec_exc_valid);
                check_cause({"ebreak cause", tag}, 4'd3, dec_exc_cause);
                check_word({"ebreak tval", tag}, '0, dec_exc_tval);
                priv_case({"mret", tag}, 32'h3020_0073, p == PRV_M, ERET);
                priv_case({"sret", tag}, 32'h1020_0073, p == PRV_M || (p == PRV_S && !b[0]),
                          ERET);
                priv_case({"wfi", tag}, 32'h1050_0073, p == PRV_M || (p == PRV_S && !b[1]),
                          WFI);
            end
        end
    endtask

    task automatic test_fetch_fault();
        xlen_t ft;
        set_priv(PRV_M, 1'b0, 1'b0);
        ft = {rand_next(), rand_next()};
        run_one("fault on illegal", 32'hffff_ffff, 1'b1, 4'd1, ft);
        check_bit("fault on illegal exc", 1'b1, dec_exc_valid);
        check_cause("fault on illegal cause", 4'd1, dec_exc_cause);
        check_word("fault on illegal tval", ft, dec_exc_tval);
        ft = {rand_next(), rand_next()};
        run_one("fault on ecall", 32'h0000_0073, 1'b1, 4'd12, ft);
        check_cause("fault on ecall cause", 4'd12, dec_exc_cause);
        check_word("fault on ecall tval", ft, dec_exc_tval);
        run_one("unknown opcode", 32'h0000_007f);
        expect_illegal("unknown opcode", 32'h0000_007f);
    endtask

    initial begin
        seed        = 32'h43a2_f718;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr_word  = '0;
        instr_pc    = '0;
        fetch_fault = 1'b0;
        fetch_cause = '0;
        fetch_tval  = '0;
        prv         = PRV_M;
        tsr         = 1'b0;
        tw          = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_timing();
        test_alu();
        test_imm();
        test_mem_branch();
        test_system();
        test_fetch_fault();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+verilog
verilog/decode_pkg.sv
verilog/op_decoder.sv
verilog/imm_gen.sv
verilog/decode_issue.sv
verilog/rv_decoder.sv
tests/decoder_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= decoder_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(BUILD_DIR)
